// ==== qpu_pkg.sv ====
`default_nettype none

package qpu_pkg;

  //////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////
  localparam int XLEN       = 32;
  localparam int INSTR_W    = 32;
  localparam int NUM_CREGS  = 16;
  localparam int NUM_MASKS  = 8;
  localparam int CREG_IDX_W = 4;
  localparam int MASK_IDX_W = 3;
  localparam int GATE_W     = 8;

  // gate code reserved for measurement events
  localparam logic [GATE_W-1:0] MEAS_GATE = 8'hff;

  //////////////////////////////////////////////////
  // instruction fields
  //////////////////////////////////////////////////
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  localparam int RD_LSB  = 24;
  localparam int RS_LSB  = 20;
  localparam int IMM_W   = 16;

  typedef enum logic [3:0] {
    OP_NOP     = 4'd0,
    OP_ADDI    = 4'd1,
    OP_QWAIT   = 4'd2,
    OP_SMIS    = 4'd3,
    OP_SMR     = 4'd4,
    OP_QOP     = 4'd5,
    OP_MEASURE = 4'd6,
    OP_FMR     = 4'd7
  } qpu_op_e;

  typedef logic [CREG_IDX_W-1:0] creg_idx_t;
  typedef logic [MASK_IDX_W-1:0] mask_idx_t;
  typedef logic [IMM_W-1:0]      imm_t;

endpackage

`default_nettype wire

// ==== qpu_exu_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded fields, decode to dispatch
interface dec_if;
  import qpu_pkg::*;

  qpu_op_e   op;
  creg_idx_t rd;
  creg_idx_t rs;
  imm_t      imm;

  modport dec  (output op, rd, rs, imm);
  modport disp (input op, rd, rs, imm);
endinterface

// issue register contents, dispatch to alu
interface issue_if #(parameter int NUM_QUBITS = 8);
  import qpu_pkg::*;

  logic                  valid;
  logic                  ready;
  qpu_op_e               op;
  creg_idx_t             rd;
  creg_idx_t             rs;
  imm_t                  imm;
  logic [NUM_QUBITS-1:0] mask;

  modport disp (output valid, op, rd, rs, imm, mask, input ready);
  modport alu  (input valid, op, rd, rs, imm, mask, output ready);
endinterface

// three write ports into the register file
interface wbck_if #(parameter int NUM_QUBITS = 8, parameter int TIME_W = 16);
  import qpu_pkg::*;

  logic                  cr_en;
  creg_idx_t             cr_idx;
  logic [XLEN-1:0]       cr_data;
  logic                  mk_en;
  mask_idx_t             mk_idx;
  logic [NUM_QUBITS-1:0] mk_data;
  logic                  tm_en;
  logic [TIME_W-1:0]     tm_data;

  modport alu (output cr_en, cr_idx, cr_data, mk_en, mk_idx, mk_data, tm_en, tm_data);
  modport rf  (input cr_en, cr_idx, cr_data, mk_en, mk_idx, mk_data, tm_en, tm_data);
endinterface

`default_nettype wire

// ==== qpu_exu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module qpu_exu_decode (
  input  wire logic [qpu_pkg::INSTR_W-1:0] i_instr,
  dec_if.dec                               o_dec
);
  import qpu_pkg::*;

  logic [OPC_MSB-OPC_LSB:0] opc;

  assign opc = i_instr[OPC_MSB:OPC_LSB];

  // unknown codes fall back to a nop
  always_comb
  begin
    case (opc)
      4'd1:    o_dec.op = OP_ADDI;
      4'd2:    o_dec.op = OP_QWAIT;
      4'd3:    o_dec.op = OP_SMIS;
      4'd4:    o_dec.op = OP_SMR;
      4'd5:    o_dec.op = OP_QOP;
      4'd6:    o_dec.op = OP_MEASURE;
      4'd7:    o_dec.op = OP_FMR;
      default: o_dec.op = OP_NOP;
    endcase
  end

  // rd and rs double as mask indices
  assign o_dec.rd  = i_instr[RD_LSB +: CREG_IDX_W];
  assign o_dec.rs  = i_instr[RS_LSB +: CREG_IDX_W];
  assign o_dec.imm = i_instr[IMM_W-1:0];

endmodule

`default_nettype wire

// ==== qpu_exu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module qpu_exu_regfile #(
  parameter int NUM_QUBITS = 8,
  parameter int TIME_W     = 16
) (
  input  wire logic                     clk,
  input  wire logic                     i_rst_n,
  wbck_if.rf                            i_wb,
  input  wire qpu_pkg::creg_idx_t       i_cr_idx,
  input  wire qpu_pkg::mask_idx_t       i_mask_idx,
  output logic [qpu_pkg::XLEN-1:0]      o_cr_data,
  output logic [NUM_QUBITS-1:0]         o_mask_data,
  output logic [TIME_W-1:0]             o_time,
  input  wire logic                     i_meas_valid,
  input  wire logic [NUM_QUBITS-1:0]    i_meas_qubits,
  input  wire logic [NUM_QUBITS-1:0]    i_meas_result,
  input  wire logic [NUM_QUBITS-1:0]    i_mrf_mask,
  output logic [NUM_QUBITS-1:0]         o_mrf_data
);
  import qpu_pkg::*;

  logic [XLEN-1:0]       cregs [NUM_CREGS];
  logic [NUM_QUBITS-1:0] masks [NUM_MASKS];
  logic [TIME_W-1:0]     timer;
  logic [NUM_QUBITS-1:0] mrf;

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < NUM_CREGS; i++)
        cregs[i] <= '0;
      for (int j = 0; j < NUM_MASKS; j++)
        masks[j] <= '0;
      timer <= '0;
      mrf   <= '0;
    end
    else
    begin
      // r0 is never written
      if (i_wb.cr_en && (i_wb.cr_idx != '0))
        cregs[i_wb.cr_idx] <= i_wb.cr_data;
      if (i_wb.mk_en)
        masks[i_wb.mk_idx] <= i_wb.mk_data;
      if (i_wb.tm_en)
        timer <= i_wb.tm_data;
      // only the returned qubits change
      if (i_meas_valid)
        mrf <= (mrf & ~i_meas_qubits) | (i_meas_result & i_meas_qubits);
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////
  assign o_cr_data   = (i_cr_idx == '0) ? '0 : cregs[i_cr_idx];
  assign o_mask_data = masks[i_mask_idx];
  assign o_time      = timer;
  assign o_mrf_data  = mrf & i_mrf_mask;

endmodule

`default_nettype wire

// ==== qpu_exu_oitf.sv ====
`timescale 1ns/1ps
`default_nettype none

module qpu_exu_oitf #(
  parameter int NUM_QUBITS = 8
) (
  input  wire logic                  clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_set_ena,
  input  wire logic [NUM_QUBITS-1:0] i_set_qubits,
  input  wire logic                  i_ret_ena,
  input  wire logic [NUM_QUBITS-1:0] i_ret_qubits,
  output logic [NUM_QUBITS-1:0]      o_pending
);

  logic [NUM_QUBITS-1:0] set_bits;
  logic [NUM_QUBITS-1:0] clr_bits;

  assign set_bits = i_set_ena ? i_set_qubits : '0;
  assign clr_bits = i_ret_ena ? i_ret_qubits : '0;

  // a new measurement wins over a return on the same edge
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      o_pending <= '0;
    else
      o_pending <= (o_pending & ~clr_bits) | set_bits;
  end

endmodule

`default_nettype wire

// ==== qpu_exu_disp.sv ====
`timescale 1ns/1ps
`default_nettype none

module qpu_exu_disp #(
  parameter int NUM_QUBITS = 8
) (
  input  wire logic                  clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_instr_valid,
  output logic                       o_instr_ready,
  dec_if.disp                        i_dec,
  output qpu_pkg::mask_idx_t         o_mask_idx,
  input  wire logic [NUM_QUBITS-1:0] i_mask_data,
  input  wire logic [NUM_QUBITS-1:0] i_pending,
  output logic                       o_meas_set,
  output logic [NUM_QUBITS-1:0]      o_meas_qubits,
  issue_if.disp                      o_iss
);
  import qpu_pkg::*;

  logic rst_done;
  logic new_reads_mask;
  logic iss_writes_mask;
  logic mask_hazard;
  logic pend_hit;
  logic slot_free;
  logic accept;

  // holds ready low for one cycle after reset
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      rst_done <= 1'b0;
    else
      rst_done <= 1'b1;
  end

  //////////////////////////////////////////////////
  // stall rules
  //////////////////////////////////////////////////
  assign o_mask_idx = i_dec.rs[MASK_IDX_W-1:0];

  assign new_reads_mask = (i_dec.op == OP_QOP) || (i_dec.op == OP_MEASURE) ||
                          (i_dec.op == OP_FMR);
  assign iss_writes_mask = o_iss.valid && ((o_iss.op == OP_SMIS) || (o_iss.op == OP_SMR));

  // mask read here would be stale
  assign mask_hazard = new_reads_mask && iss_writes_mask &&
                       (o_iss.rd[MASK_IDX_W-1:0] == o_mask_idx);
  // wait for the measurement return
  assign pend_hit    = new_reads_mask && (|(i_mask_data & i_pending));
  assign slot_free   = !o_iss.valid || o_iss.ready;

  assign o_instr_ready = rst_done && slot_free && !pend_hit && !mask_hazard;
  assign accept        = i_instr_valid && o_instr_ready;

  // qubits that become pending
  assign o_meas_set    = accept && (i_dec.op == OP_MEASURE);
  assign o_meas_qubits = i_mask_data;

  //////////////////////////////////////////////////
  // issue register
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      o_iss.valid <= 1'b0;
    else if (accept)
      o_iss.valid <= 1'b1;
    else if (o_iss.ready)
      o_iss.valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      o_iss.op   <= i_dec.op;
      o_iss.rd   <= i_dec.rd;
      o_iss.rs   <= i_dec.rs;
      o_iss.imm  <= i_dec.imm;
      o_iss.mask <= i_mask_data;
    end
  end

endmodule

`default_nettype wire

// ==== qpu_exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module qpu_exu_alu #(
  parameter int NUM_QUBITS = 8,
  parameter int TIME_W     = 16
) (
  input  wire logic                      clk,
  input  wire logic                      i_rst_n,
  issue_if.alu                           i_iss,
  wbck_if.alu                            o_wb,
  output qpu_pkg::creg_idx_t             o_cr_idx,
  input  wire logic [qpu_pkg::XLEN-1:0]  i_cr_data,
  input  wire logic [TIME_W-1:0]         i_time,
  output logic [NUM_QUBITS-1:0]          o_mrf_mask,
  input  wire logic [NUM_QUBITS-1:0]     i_mrf_data,
  output logic                           o_evt_valid,
  output logic [TIME_W-1:0]              o_evt_time,
  output logic [qpu_pkg::GATE_W-1:0]     o_evt_gate,
  output logic [NUM_QUBITS-1:0]          o_evt_qubits,
  input  wire logic                      i_evt_ready
);
  import qpu_pkg::*;

  logic            is_evt;
  logic            is_meas;
  logic            fire;
  logic [XLEN-1:0] imm_sext;

  assign is_meas = (i_iss.op == OP_MEASURE);
  assign is_evt  = (i_iss.op == OP_QOP) || is_meas;

  // an event needs room in the output register
  assign i_iss.ready = !(is_evt && o_evt_valid && !i_evt_ready);
  assign fire        = i_iss.valid && i_iss.ready;

  //////////////////////////////////////////////////
  // operand reads
  //////////////////////////////////////////////////
  assign o_cr_idx   = i_iss.rs;
  assign o_mrf_mask = i_iss.mask;
  assign imm_sext   = {{(XLEN-IMM_W){i_iss.imm[IMM_W-1]}}, i_iss.imm};

  //////////////////////////////////////////////////
  // write-back
  //////////////////////////////////////////////////
  assign o_wb.cr_en   = fire && ((i_iss.op == OP_ADDI) || (i_iss.op == OP_FMR));
  assign o_wb.cr_idx  = i_iss.rd;
  assign o_wb.cr_data = (i_iss.op == OP_ADDI) ? (i_cr_data + imm_sext) : XLEN'(i_mrf_data);

  // smis takes the immediate, smr a classical register
  assign o_wb.mk_en   = fire && ((i_iss.op == OP_SMIS) || (i_iss.op == OP_SMR));
  assign o_wb.mk_idx  = i_iss.rd[MASK_IDX_W-1:0];
  assign o_wb.mk_data = (i_iss.op == OP_SMIS) ? NUM_QUBITS'(i_iss.imm) :
                                                 i_cr_data[NUM_QUBITS-1:0];

  assign o_wb.tm_en   = fire && (i_iss.op == OP_QWAIT);
  assign o_wb.tm_data = i_time + TIME_W'(i_iss.imm);

  //////////////////////////////////////////////////
  // event output register
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      o_evt_valid <= 1'b0;
    else if (fire && is_evt)
      o_evt_valid <= 1'b1;
    else if (i_evt_ready)
      o_evt_valid <= 1'b0;
  end

  // stamped with the timer before any qwait in flight
  always_ff @(posedge clk)
  begin
    if (fire && is_evt)
    begin
      o_evt_time   <= i_time;
      o_evt_gate   <= is_meas ? MEAS_GATE : i_iss.imm[GATE_W-1:0];
      o_evt_qubits <= i_iss.mask;
    end
  end

endmodule

`default_nettype wire

// ==== qpu_exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module qpu_exu_top #(
  parameter int NUM_QUBITS = 8,
  parameter int TIME_W     = 16
) (
  input  wire logic                         clk,
  input  wire logic                         i_rst_n,
  input  wire logic                         i_instr_valid,
  output logic                              o_instr_ready,
  input  wire logic [qpu_pkg::INSTR_W-1:0]  i_instr,
  output logic                              o_evt_valid,
  input  wire logic                         i_evt_ready,
  output logic [TIME_W-1:0]                 o_evt_time,
  output logic [qpu_pkg::GATE_W-1:0]        o_evt_gate,
  output logic [NUM_QUBITS-1:0]             o_evt_qubits,
  input  wire logic                         i_meas_valid,
  input  wire logic [NUM_QUBITS-1:0]        i_meas_qubits,
  input  wire logic [NUM_QUBITS-1:0]        i_meas_result
);
  import qpu_pkg::*;

  dec_if                                                  u_dec_if ();
  issue_if #(.NUM_QUBITS(NUM_QUBITS))                     u_iss_if ();
  wbck_if  #(.NUM_QUBITS(NUM_QUBITS), .TIME_W(TIME_W))    u_wb_if ();

  creg_idx_t             cr_idx;
  logic [XLEN-1:0]       cr_data;
  logic [TIME_W-1:0]     cur_time;
  mask_idx_t             mask_idx;
  logic [NUM_QUBITS-1:0] mask_data;
  logic [NUM_QUBITS-1:0] pending;
  logic                  meas_set;
  logic [NUM_QUBITS-1:0] meas_qubits;
  logic [NUM_QUBITS-1:0] mrf_mask;
  logic [NUM_QUBITS-1:0] mrf_data;

  qpu_exu_decode u_decode (
    .i_instr (i_instr),
    .o_dec   (u_dec_if.dec)
  );

  qpu_exu_disp #(.NUM_QUBITS(NUM_QUBITS)) u_disp (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_dec         (u_dec_if.disp),
    .o_mask_idx    (mask_idx),
    .i_mask_data   (mask_data),
    .i_pending     (pending),
    .o_meas_set    (meas_set),
    .o_meas_qubits (meas_qubits),
    .o_iss         (u_iss_if.disp)
  );

  // measurement returns go to both the scoreboard and the result register
  qpu_exu_oitf #(.NUM_QUBITS(NUM_QUBITS)) u_oitf (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_set_ena    (meas_set),
    .i_set_qubits (meas_qubits),
    .i_ret_ena    (i_meas_valid),
    .i_ret_qubits (i_meas_qubits),
    .o_pending    (pending)
  );

  qpu_exu_regfile #(.NUM_QUBITS(NUM_QUBITS), .TIME_W(TIME_W)) u_regfile (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_wb          (u_wb_if.rf),
    .i_cr_idx      (cr_idx),
    .i_mask_idx    (mask_idx),
    .o_cr_data     (cr_data),
    .o_mask_data   (mask_data),
    .o_time        (cur_time),
    .i_meas_valid  (i_meas_valid),
    .i_meas_qubits (i_meas_qubits),
    .i_meas_result (i_meas_result),
    .i_mrf_mask    (mrf_mask),
    .o_mrf_data    (mrf_data)
  );

  qpu_exu_alu #(.NUM_QUBITS(NUM_QUBITS), .TIME_W(TIME_W)) u_alu (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_iss        (u_iss_if.alu),
    .o_wb         (u_wb_if.alu),
    .o_cr_idx     (cr_idx),
    .i_cr_data    (cr_data),
    .i_time       (cur_time),
    .o_mrf_mask   (mrf_mask),
    .i_mrf_data   (mrf_data),
    .o_evt_valid  (o_evt_valid),
    .o_evt_time   (o_evt_time),
    .o_evt_gate   (o_evt_gate),
    .o_evt_qubits (o_evt_qubits),
    .i_evt_ready  (i_evt_ready)
  );

endmodule

`default_nettype wire

// ==== tb_qpu_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_qpu_exu;
  import qpu_pkg::*;

  localparam int NUM_QUBITS   = 8;
  localparam int TIME_W       = 16;
  localparam int RST_CYCLES   = 8;
  localparam int NUM_ROWS     = 19;
  localparam int TIMEOUT      = 40 * NUM_ROWS + RST_CYCLES;
  localparam int DRAIN_LIMIT  = 100;
  localparam int SEED         = 32'h3f12_854c;

  typedef struct {
    string                 name;
    logic [INSTR_W-1:0]    instr;
    bit                    has_evt;
    logic [TIME_W-1:0]     t;
    logic [GATE_W-1:0]     g;
    logic [NUM_QUBITS-1:0] q;
    bit                    has_ret;
    logic [NUM_QUBITS-1:0] ret_q;
    logic [NUM_QUBITS-1:0] ret_r;
  } row_t;

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_instr_valid;
  logic                  o_instr_ready;
  logic [INSTR_W-1:0]    i_instr;
  logic                  o_evt_valid;
  logic                  i_evt_ready;
  logic [TIME_W-1:0]     o_evt_time;
  logic [GATE_W-1:0]     o_evt_gate;
  logic [NUM_QUBITS-1:0] o_evt_qubits;
  logic                  i_meas_valid;
  logic [NUM_QUBITS-1:0] i_meas_qubits;
  logic [NUM_QUBITS-1:0] i_meas_result;

  row_t tbl[$];
  int   exp_q[$];
  int   cycles;

  qpu_exu_top #(.NUM_QUBITS(NUM_QUBITS), .TIME_W(TIME_W)) u_qpu_exu_top (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_instr       (i_instr),
    .o_evt_valid   (o_evt_valid),
    .i_evt_ready   (i_evt_ready),
    .o_evt_time    (o_evt_time),
    .o_evt_gate    (o_evt_gate),
    .o_evt_qubits  (o_evt_qubits),
    .i_meas_valid  (i_meas_valid),
    .i_meas_qubits (i_meas_qubits),
    .i_meas_result (i_meas_result)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [INSTR_W-1:0] encode(input qpu_op_e op, input logic [3:0] rd,
                                                input logic [3:0] rs, input logic [15:0] imm);
    encode = {op, rd, rs, 4'h0, imm};
  endfunction

  task automatic add_row(input string name, input logic [INSTR_W-1:0] instr, input bit ev,
                         input logic [TIME_W-1:0] t, input logic [GATE_W-1:0] g,
                         input logic [NUM_QUBITS-1:0] q, input bit ret,
                         input logic [NUM_QUBITS-1:0] rq, input logic [NUM_QUBITS-1:0] rr);
    row_t rw;
    rw.name    = name;
    rw.instr   = instr;
    rw.has_evt = ev;
    rw.t       = t;
    rw.g       = g;
    rw.q       = q;
    rw.has_ret = ret;
    rw.ret_q   = rq;
    rw.ret_r   = rr;
    tbl.push_back(rw);
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_time(input string name, input logic [TIME_W-1:0] expected,
                            input logic [TIME_W-1:0] actual);
    if (actual !== expected)
      report_failure($sformatf("Mismatch %s time: expected %0h, actual %0h",
                               name, expected, actual));
  endtask

  task automatic check_gate(input string name, input logic [GATE_W-1:0] expected,
                            input logic [GATE_W-1:0] actual);
    if (actual !== expected)
      report_failure($sformatf("Mismatch %s gate: expected %0h, actual %0h",
                               name, expected, actual));
  endtask

  task automatic check_qubits(input string name, input logic [NUM_QUBITS-1:0] expected,
                              input logic [NUM_QUBITS-1:0] actual);
    if (actual !== expected)
      report_failure($sformatf("Mismatch %s qubits: expected %0h, actual %0h",
                               name, expected, actual));
  endtask

  task automatic check_ready(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      report_failure($sformatf("Mismatch %s ready: expected %0b, actual %0b",
                               name, expected, actual));
  endtask

  //////////////////////////////////////////////////
  // program table
  //////////////////////////////////////////////////
  task automatic build_table();
    add_row("smis_m1", encode(OP_SMIS, 4'd1, 4'd0, 16'h0005),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    add_row("qop_t0", encode(OP_QOP, 4'd0, 4'd1, 16'h0012),
            1'b1, 16'd0, 8'h12, 8'h05, 1'b0, 8'h00, 8'h00);
    add_row("qwait_10", encode(OP_QWAIT, 4'd0, 4'd0, 16'd10),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    add_row("qop_t10", encode(OP_QOP, 4'd0, 4'd1, 16'h0021),
            1'b1, 16'd10, 8'h21, 8'h05, 1'b0, 8'h00, 8'h00);
    add_row("addi_r3", encode(OP_ADDI, 4'd3, 4'd0, 16'h00a6),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    add_row("smr_m2", encode(OP_SMR, 4'd2, 4'd3, 16'h0000),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    // mask 2 written just before, read here
    add_row("qop_m2", encode(OP_QOP, 4'd0, 4'd2, 16'h0033),
            1'b1, 16'd10, 8'h33, 8'ha6, 1'b0, 8'h00, 8'h00);
    add_row("qwait_7", encode(OP_QWAIT, 4'd0, 4'd0, 16'd7),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    add_row("meas_m1", encode(OP_MEASURE, 4'd0, 4'd1, 16'h0000),
            1'b1, 16'd17, MEAS_GATE, 8'h05, 1'b0, 8'h00, 8'h00);
    add_row("smis_m3", encode(OP_SMIS, 4'd3, 4'd0, 16'h0030),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    // disjoint from the pending qubits
    add_row("qop_free", encode(OP_QOP, 4'd0, 4'd3, 16'h0044),
            1'b1, 16'd17, 8'h44, 8'h30, 1'b0, 8'h00, 8'h00);
    // overlaps qubit 2, waits for the return
    add_row("fmr_r5", encode(OP_FMR, 4'd5, 4'd2, 16'h0000),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b1, 8'h05, 8'hfd);
    add_row("smr_m5", encode(OP_SMR, 4'd5, 4'd5, 16'h0000),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    add_row("qop_m5", encode(OP_QOP, 4'd0, 4'd5, 16'h0055),
            1'b1, 16'd17, 8'h55, 8'h04, 1'b0, 8'h00, 8'h00);
    add_row("addi_neg", encode(OP_ADDI, 4'd6, 4'd3, 16'hfffe),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    add_row("smr_m6", encode(OP_SMR, 4'd6, 4'd6, 16'h0000),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    add_row("qop_m6", encode(OP_QOP, 4'd0, 4'd6, 16'h0066),
            1'b1, 16'd17, 8'h66, 8'ha4, 1'b0, 8'h00, 8'h00);
    add_row("qwait_big", encode(OP_QWAIT, 4'd0, 4'd0, 16'h8000),
            1'b0, 16'd0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00);
    add_row("qop_big", encode(OP_QOP, 4'd0, 4'd6, 16'h0177),
            1'b1, 16'h8011, 8'h77, 8'ha4, 1'b0, 8'h00, 8'h00);
  endtask

  //////////////////////////////////////////////////
  // clock, back-pressure, monitor, timeout
  //////////////////////////////////////////////////
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // random gaps on the event output
  initial
  begin
    void'($urandom(SEED));
    i_evt_ready = 1'b0;
    forever
    begin
      @(posedge clk);
      i_evt_ready <= (($urandom % 4) != 0);
    end
  end

  // handshake seen at negedge completes on the next rising edge
  always @(negedge clk)
  begin
    int idx;
    if (i_rst_n && o_evt_valid && i_evt_ready)
    begin
      if (exp_q.size() == 0)
        report_failure("event handshake seen with no event expected");
      else
      begin
        idx = exp_q.pop_front();
        check_time(tbl[idx].name, tbl[idx].t, o_evt_time);
        check_gate(tbl[idx].name, tbl[idx].g, o_evt_gate);
        check_qubits(tbl[idx].name, tbl[idx].q, o_evt_qubits);
      end
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT)
      report_failure("run exceeded its cycle limit");
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial
  begin
    int  waited;
    int  limit;
    bit  accepted;
    cycles        = 0;
    i_rst_n       = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_meas_valid  = 1'b0;
    i_meas_qubits = '0;
    i_meas_result = '0;
    build_table();

    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_ready("in_reset", 1'b0, o_instr_ready);
    @(posedge clk);
    i_rst_n <= 1'b1;
    @(negedge clk);
    check_ready("evt_after_reset", 1'b0, o_evt_valid);
    check_ready("instr_after_reset", 1'b0, o_instr_ready);
    @(posedge clk);

    for (int r = 0; r < tbl.size(); r++)
    begin
      i_instr_valid <= 1'b1;
      i_instr       <= tbl[r].instr;
      if (tbl[r].has_evt)
        exp_q.push_back(r);
      if (tbl[r].has_ret)
      begin
        // must stay stalled until the return
        repeat (4)
        begin
          @(negedge clk);
          check_ready(tbl[r].name, 1'b0, o_instr_ready);
          @(posedge clk);
        end
        i_meas_valid  <= 1'b1;
        i_meas_qubits <= tbl[r].ret_q;
        i_meas_result <= tbl[r].ret_r;
        @(posedge clk);
        i_meas_valid  <= 1'b0;
      end
      limit    = (r == 0) ? 3 : 30;
      waited   = 0;
      accepted = 1'b0;
      while (!accepted)
      begin
        @(negedge clk);
        accepted = o_instr_ready;
        waited++;
        if (!accepted && (waited > limit))
          report_failure({"instruction not accepted in time: ", tbl[r].name});
        @(posedge clk);
      end
    end
    i_instr_valid <= 1'b0;

    waited = 0;
    while ((exp_q.size() != 0) && (waited < DRAIN_LIMIT))
    begin
      @(negedge clk);
      waited++;
    end
    // catch stray events
    repeat (10) @(negedge clk);

    if (exp_q.size() == 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
      report_failure("expected events never arrived");
  end

endmodule

`default_nettype wire

// ==== list.f ====
qpu_pkg.sv
qpu_exu_if.sv
qpu_exu_decode.sv
qpu_exu_regfile.sv
qpu_exu_oitf.sv
qpu_exu_disp.sv
qpu_exu_alu.sv
qpu_exu_top.sv
tb_qpu_exu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module tb_qpu_exu -o sim_qpu_exu \
  && ./obj_dir/sim_qpu_exu \
  || exit 1
